// File: logic/mem_map_pkg.sv
/*
 * Instruction memory map shared by the fetch RTL and the testbench
 * Widths, base address, depth and the address, word and index types
 * Import where memory sizes or addresses are needed
 */

package mem_map_pkg;

    // ====================
    // Widths
    // ====================
    localparam int unsigned addr_w     = 32;  // Byte address width
    localparam int unsigned word_w     = 32;  // Instruction word width
    localparam int unsigned mem_depth  = 256; // Instruction words
    localparam int unsigned word_idx_w = 8;   // log2(mem_depth)

    // ====================
    // Types
    // ====================
    typedef logic [addr_w-1:0]     addr_t;     // Byte address
    typedef logic [word_w-1:0]     word_t;     // One instruction
    typedef logic [word_idx_w-1:0] word_idx_t; // Index into the memory

    localparam addr_t inst_base_addr = 32'h8000_0000; // Byte address of word 0

endpackage

// File: logic/fetch_pkg.sv
/*
 * Fetch side definitions: lane count, PC stride per bundle,
 * the NOP placed in faulted slots and the lane FSM states
 * Compile after mem_map_pkg
 */

package fetch_pkg;

    // ====================
    // Bundle shape
    // ====================
    localparam int unsigned num_lanes     = 3;             // Fetch width
    localparam int unsigned bundle_stride = 4 * num_lanes; // PC advance per bundle, 12 bytes

    // Canonical NOP, ADDI x0, x0, 0
    localparam mem_map_pkg::word_t nop_insn = 32'h0000_0013;

    // ====================
    // Lane FSM
    // ====================
    // lane_idle  free, can take a request
    // lane_wait  memory read in flight
    // lane_full  result held until the collector pops it
    typedef enum logic [1:0] {
        lane_idle = 2'd0,
        lane_wait = 2'd1,
        lane_full = 2'd2
    } lane_state_t;

endpackage

// File: logic/inst_mem.sv
/*
 * Instruction memory with one synchronous read port per fetch lane
 * and a whole-word write port used to load the program
 * Read data is valid the cycle after rd_en
 */

`timescale 1ns/1ps

module inst_mem (
    input  logic                                                 clk,
    input  logic                                                 load_valid_i, // Write strobe
    input  mem_map_pkg::word_idx_t                               load_idx_i,
    input  mem_map_pkg::word_t                                   load_data_i,
    input  logic [fetch_pkg::num_lanes-1:0]                      rd_en_i,
    input  mem_map_pkg::word_idx_t [fetch_pkg::num_lanes-1:0]    rd_idx_i,
    output mem_map_pkg::word_t [fetch_pkg::num_lanes-1:0]        rd_data_o
);

    import mem_map_pkg::*;
    import fetch_pkg::*;

    word_t mem [mem_depth]; // Program storage

    // Program load, one word per cycle
    always_ff @(posedge clk) begin
        if (load_valid_i) begin
            mem[load_idx_i] <= load_data_i;
        end
    end

    // Registered reads, port k serves lane k
    always_ff @(posedge clk) begin
        for (int k = 0; k < num_lanes; k++) begin
            if (rd_en_i[k]) begin
                rd_data_o[k] <= mem[rd_idx_i[k]]; // Range already checked by the lane
            end
        end
    end

    // ====================
    // Checks
    // ====================
    for (genvar k = 0; k < num_lanes; k++) begin : g_rd_chk
        // Lane must hand a clean index with every read
        a_rd_idx_known: assert property (@(posedge clk) rd_en_i[k] |-> !$isunknown(rd_idx_i[k]))
            else $error("inst_mem port %0d read with unknown index", k);
    end

endmodule

// File: logic/fetch_sequencer.sv
/*
 * Fetch PC owner: issues PC, PC+4, PC+8 to the three lanes when all
 * of them are ready, then steps the PC by one bundle
 * A redirect reloads the PC and flushes lanes and collector
 */

`timescale 1ns/1ps

module fetch_sequencer (
    input  logic                                             clk,
    input  logic                                             rst_n,          // Sync, active high
    input  logic                                             redirect_valid_i,
    input  mem_map_pkg::addr_t                               redirect_pc_i,
    input  logic [fetch_pkg::num_lanes-1:0]                  lane_ready_i,
    output logic [fetch_pkg::num_lanes-1:0]                  req_valid_o,
    output mem_map_pkg::addr_t [fetch_pkg::num_lanes-1:0]    req_addr_o,
    output mem_map_pkg::addr_t                               bundle_pc_o,    // PC of bundle in lanes
    output logic                                             flush_o
);

    import mem_map_pkg::*;
    import fetch_pkg::*;

    addr_t pc_q;  // Next bundle PC
    logic  issue; // All lanes take a request this cycle

    // Redirect wins over a normal issue
    assign issue       = (&lane_ready_i) && !redirect_valid_i;
    assign req_valid_o = {num_lanes{issue}}; // All lanes together or none
    assign flush_o     = redirect_valid_i;   // One cycle per taken redirect

    // Lane k fetches word k of the bundle
    for (genvar k = 0; k < num_lanes; k++) begin : g_addr
        assign req_addr_o[k] = pc_q + addr_t'(4 * k);
    end

    // ====================
    // PC register
    // ====================
    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc_q <= inst_base_addr; // Boot from word 0
        end else if (redirect_valid_i) begin
            pc_q <= redirect_pc_i;
        end else if (issue) begin
            pc_q <= pc_q + addr_t'(bundle_stride);
        end
    end

    // PC of the bundle now sitting in the lanes, sampled by the collector on pop
    always_ff @(posedge clk) begin
        if (issue) begin
            bundle_pc_o <= pc_q;
        end
    end

    // Redirect targets must be word aligned, or lanes would split words
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst_n) pc_q[1:0] == 2'b00)
        else $error("fetch PC not word aligned: %h", pc_q);

endmodule

// File: logic/fetch_lane.sv
/*
 * One fetch lane: takes an address from the sequencer, reads its own
 * memory port, range-checks the address and holds the word until the
 * collector pops it. Out of range slots return a NOP with fault set
 */

`timescale 1ns/1ps

module fetch_lane (
    input  logic                  clk,
    input  logic                  rst_n,      // Sync, active high
    input  logic                  flush_i,    // Drop whatever is in flight
    input  logic                  req_valid_i,
    input  mem_map_pkg::addr_t    req_addr_i,
    output logic                  req_ready_o,
    output logic                  rd_en_o,
    output mem_map_pkg::word_idx_t rd_idx_o,
    input  mem_map_pkg::word_t    rd_data_i,  // Arrives one cycle after rd_en_o
    output logic                  res_valid_o,
    output mem_map_pkg::word_t    res_insn_o,
    output logic                  res_fault_o,
    input  logic                  pop_i       // Collector takes the result
);

    import mem_map_pkg::*;
    import fetch_pkg::*;

    lane_state_t state_q;
    addr_t       offset;     // Byte offset from the memory base
    logic        addr_fault; // Request outside the memory
    logic        accept;     // Request taken this cycle
    logic        fault_q;
    word_t       insn_q;

    // ====================
    // Request side
    // ====================
    assign addr_fault = (req_addr_i < inst_base_addr) ||
                        (req_addr_i >= inst_base_addr + addr_t'(4 * mem_depth));
    assign offset     = req_addr_i - inst_base_addr;
    assign rd_idx_o   = offset[word_idx_w+1:2]; // Word index

    // Free when idle, or when the held result leaves this edge
    assign req_ready_o = (state_q == lane_idle) || (state_q == lane_full && pop_i);
    assign accept      = req_valid_i && req_ready_o;
    assign rd_en_o     = accept && !addr_fault; // No read for a faulted slot

    // ====================
    // FSM
    // ====================
    always_ff @(posedge clk) begin
        if (rst_n) begin
            state_q <= lane_idle;
        end else if (flush_i) begin
            state_q <= lane_idle;
        end else begin
            case (state_q)
                lane_idle: begin
                    if (req_valid_i) state_q <= lane_wait;
                end
                lane_wait: state_q <= lane_full; // Memory data lands now
                lane_full: begin
                    if (pop_i) state_q <= req_valid_i ? lane_wait : lane_idle; // Back to back
                end
                default: state_q <= lane_idle;
            endcase
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (accept) begin
            fault_q <= addr_fault;
        end
        if (state_q == lane_wait) begin
            insn_q <= fault_q ? nop_insn : rd_data_i;
        end
    end

    assign res_valid_o = (state_q == lane_full);
    assign res_insn_o  = insn_q;
    assign res_fault_o = fault_q;

    // Collector only pops when every lane holds a result
    a_pop_when_full: assert property (@(posedge clk) disable iff (rst_n)
        pop_i |-> state_q == lane_full)
        else $error("pop while lane not full");

endmodule

// File: logic/bundle_collector.sv
/*
 * Joins the three lane results into one registered bundle with a
 * valid/ready handshake. Lanes are popped on the edge that loads the
 * output register, so the next fetch overlaps the current output
 */

`timescale 1ns/1ps

module bundle_collector (
    input  logic                                             clk,
    input  logic                                             rst_n,       // Sync, active high
    input  logic                                             flush_i,
    input  logic [fetch_pkg::num_lanes-1:0]                  lane_valid_i,
    input  mem_map_pkg::word_t [fetch_pkg::num_lanes-1:0]    lane_insn_i,
    input  logic [fetch_pkg::num_lanes-1:0]                  lane_fault_i,
    input  mem_map_pkg::addr_t                               pc_i,        // PC of bundle in lanes
    output logic                                             pop_o,
    output logic                                             bundle_valid_o,
    output mem_map_pkg::addr_t                               bundle_pc_o,
    output mem_map_pkg::word_t [fetch_pkg::num_lanes-1:0]    bundle_insn_o,
    output logic [fetch_pkg::num_lanes-1:0]                  bundle_fault_o,
    input  logic                                             bundle_ready_i
);

    logic out_free; // Output register empty or leaving this edge

    assign out_free = !bundle_valid_o || bundle_ready_i;
    assign pop_o    = (&lane_valid_i) && out_free && !flush_i; // Load and pop together

    // ====================
    // Output register
    // ====================
    always_ff @(posedge clk) begin
        if (rst_n) begin
            bundle_valid_o <= 1'b0;
        end else if (flush_i) begin
            bundle_valid_o <= 1'b0; // Drop old-path bundle
        end else if (pop_o) begin
            bundle_valid_o <= 1'b1;
        end else if (bundle_ready_i) begin
            bundle_valid_o <= 1'b0; // Taken, nothing behind it
        end
    end

    // Payload. The sequencer holds the in-lane PC, this register holds
    // the output PC, so each of the two bundles in flight keeps its own
    always_ff @(posedge clk) begin
        if (pop_o) begin
            bundle_pc_o    <= pc_i;
            bundle_insn_o  <= lane_insn_i;
            bundle_fault_o <= lane_fault_i;
        end
    end

    // Stalled bundle must not change under the consumer
    a_hold_stable: assert property (@(posedge clk) disable iff (rst_n)
        bundle_valid_o && !bundle_ready_i && !flush_i |=>
            bundle_valid_o && $stable(bundle_pc_o) && $stable(bundle_insn_o) &&
            $stable(bundle_fault_o))
        else $error("bundle changed while stalled");

endmodule

// File: logic/fetch_top.sv
/*
 * 3-wide fetch subsystem top: sequencer, instruction memory,
 * three fetch lanes and the bundle collector
 * Load the program through the load port, then take bundles
 */

`timescale 1ns/1ps

module fetch_top (
    input  logic                                             clk,
    input  logic                                             rst_n,          // Sync, active high
    input  logic                                             load_valid_i,
    input  mem_map_pkg::word_idx_t                           load_idx_i,
    input  mem_map_pkg::word_t                               load_data_i,
    input  logic                                             redirect_valid_i,
    input  mem_map_pkg::addr_t                               redirect_pc_i,
    output logic                                             bundle_valid_o,
    output mem_map_pkg::addr_t                               bundle_pc_o,
    output mem_map_pkg::word_t [fetch_pkg::num_lanes-1:0]    bundle_insn_o,
    output logic [fetch_pkg::num_lanes-1:0]                  bundle_fault_o,
    input  logic                                             bundle_ready_i
);

    import mem_map_pkg::*;
    import fetch_pkg::*;

    // ====================
    // Internal wires
    // ====================
    logic      [num_lanes-1:0] req_valid, req_ready;   // Sequencer to lanes
    addr_t     [num_lanes-1:0] req_addr;
    logic      [num_lanes-1:0] rd_en;                  // Lanes to memory
    word_idx_t [num_lanes-1:0] rd_idx;
    word_t     [num_lanes-1:0] rd_data;
    logic      [num_lanes-1:0] res_valid, res_fault;   // Lanes to collector
    word_t     [num_lanes-1:0] res_insn;
    addr_t                     issue_pc;
    logic                      flush, pop;

    fetch_sequencer u_seq (
        .clk(clk), .rst_n(rst_n),
        .redirect_valid_i(redirect_valid_i), .redirect_pc_i(redirect_pc_i),
        .lane_ready_i(req_ready), .req_valid_o(req_valid), .req_addr_o(req_addr),
        .bundle_pc_o(issue_pc), .flush_o(flush)
    );

    inst_mem u_mem (
        .clk(clk),
        .load_valid_i(load_valid_i), .load_idx_i(load_idx_i), .load_data_i(load_data_i),
        .rd_en_i(rd_en), .rd_idx_i(rd_idx), .rd_data_o(rd_data)
    );

    // One lane per memory port
    for (genvar k = 0; k < num_lanes; k++) begin : g_lane
        fetch_lane u_lane (
            .clk(clk), .rst_n(rst_n), .flush_i(flush),
            .req_valid_i(req_valid[k]), .req_addr_i(req_addr[k]), .req_ready_o(req_ready[k]),
            .rd_en_o(rd_en[k]), .rd_idx_o(rd_idx[k]), .rd_data_i(rd_data[k]),
            .res_valid_o(res_valid[k]), .res_insn_o(res_insn[k]), .res_fault_o(res_fault[k]),
            .pop_i(pop)
        );
    end

    bundle_collector u_coll (
        .clk(clk), .rst_n(rst_n), .flush_i(flush),
        .lane_valid_i(res_valid), .lane_insn_i(res_insn), .lane_fault_i(res_fault),
        .pc_i(issue_pc), .pop_o(pop),
        .bundle_valid_o(bundle_valid_o), .bundle_pc_o(bundle_pc_o),
        .bundle_insn_o(bundle_insn_o), .bundle_fault_o(bundle_fault_o),
        .bundle_ready_i(bundle_ready_i)
    );

endmodule

// File: verif/fetch_tb.sv
/*
 * Testbench for the 3-wide fetch subsystem
 * Loads an LCG program during reset, then walks a stimulus table of
 * redirects, ready patterns and bundle counts against a reference model
 */

`timescale 1ns/1ps

module fetch_tb;

    import mem_map_pkg::*;
    import fetch_pkg::*;

    localparam int clk_half   = 20; // 40 ns period
    localparam int drive_dly  = 2;  // Inputs change this long after the rising edge
    localparam int wait_limit = 40; // Cycles allowed without a bundle transfer

    typedef struct {
        logic        redir;     // Redirect before taking bundles
        addr_t       pc;        // Redirect target
        int          n;         // Bundles to take
        logic [7:0]  ready_pat; // Ready per cycle, indexed by cycle mod 8
        logic        reload;    // Rewrite the target word first
        string       name;
    } row_t;

    logic                      clk, rst_n;
    logic                      load_valid_i, redirect_valid_i, bundle_ready_i;
    word_idx_t                 load_idx_i;
    word_t                     load_data_i;
    addr_t                     redirect_pc_i, bundle_pc_o, exp_pc;
    logic                      bundle_valid_o;
    word_t [num_lanes-1:0]     bundle_insn_o;
    logic  [num_lanes-1:0]     bundle_fault_o;

    word_t       ref_mem [mem_depth]; // Reference copy of the program
    logic [31:0] lcg_state;
    logic [31:0] cyc;                 // Drive points since start
    row_t        stim [$];

    fetch_top u_fetch_top (
        .clk(clk), .rst_n(rst_n),
        .load_valid_i(load_valid_i), .load_idx_i(load_idx_i), .load_data_i(load_data_i),
        .redirect_valid_i(redirect_valid_i), .redirect_pc_i(redirect_pc_i),
        .bundle_valid_o(bundle_valid_o), .bundle_pc_o(bundle_pc_o),
        .bundle_insn_o(bundle_insn_o), .bundle_fault_o(bundle_fault_o),
        .bundle_ready_i(bundle_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // ====================
    // Model and helpers
    // ====================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic in_range(input addr_t a);
        return (a >= inst_base_addr) && (a < inst_base_addr + addr_t'(4 * mem_depth));
    endfunction

    function automatic word_t exp_word(input addr_t a);
        if (!in_range(a)) return nop_insn; // Faulted slot carries a NOP
        return ref_mem[word_idx_t'((a - inst_base_addr) >> 2)];
    endfunction

    function automatic logic [num_lanes-1:0] exp_faults(input addr_t pc);
        logic [num_lanes-1:0] f;
        for (int k = 0; k < num_lanes; k++) f[k] = !in_range(pc + addr_t'(4 * k));
        return f;
    endfunction

    task automatic next_drive();
        @(posedge clk);
        #drive_dly;
        cyc = cyc + 1;
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_fault(input string name, input logic [num_lanes-1:0] exp,
                               input logic [num_lanes-1:0] act);
        if (act !== exp) abort_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic add_row(input logic redir, input addr_t pc, input int n,
                           input logic [7:0] pat, input logic reload, input string name);
        row_t r;
        r.redir = redir;
        r.pc = pc;
        r.n = n;
        r.ready_pat = pat;
        r.reload = reload;
        r.name = name;
        stim.push_back(r);
    endtask

    // ====================
    // Stimulus steps
    // ====================
    task automatic load_program();
        for (int i = 0; i < mem_depth; i++) begin
            lcg_state = lcg_next(lcg_state);
            ref_mem[i] = lcg_state;
            load_valid_i = 1'b1;
            load_idx_i = word_idx_t'(i);
            load_data_i = lcg_state;
            next_drive();
        end
        load_valid_i = 1'b0;
    endtask

    // New word at the target, written one cycle ahead of the redirect
    task automatic rewrite_word(input addr_t pc);
        word_idx_t idx;
        idx = word_idx_t'((pc - inst_base_addr) >> 2);
        lcg_state = lcg_next(lcg_state);
        ref_mem[idx] = lcg_state;
        bundle_ready_i = 1'b0;
        load_valid_i = 1'b1;
        load_idx_i = idx;
        load_data_i = lcg_state;
        next_drive();
        load_valid_i = 1'b0;
    endtask

    task automatic redirect_to(input addr_t pc, input string name);
        bundle_ready_i = 1'b0;   // Nothing transfers on the redirect edge
        redirect_valid_i = 1'b1;
        redirect_pc_i = pc;
        next_drive();
        redirect_valid_i = 1'b0;
        if (bundle_valid_o) abort_run($sformatf("%s: old bundle still valid after redirect", name));
    endtask

    // Outputs are registered, so they are read at the drive point with ready already set
    task automatic take_bundles(input row_t r, inout addr_t pc);
        int                    taken;
        int                    idle;
        logic                  held;
        addr_t                 held_pc;
        word_t [num_lanes-1:0] held_insn;
        logic  [num_lanes-1:0] held_fault;
        taken = 0;
        idle = 0;
        held = 1'b0;
        while (taken < r.n) begin
            bundle_ready_i = r.ready_pat[cyc[2:0]];
            if (held) begin // Stalled last cycle, bundle must not move
                if (!bundle_valid_o) abort_run($sformatf("%s: bundle dropped while stalled", r.name));
                check_addr({r.name, " stall pc"}, held_pc, bundle_pc_o);
                for (int k = 0; k < num_lanes; k++)
                    check_word($sformatf("%s stall slot %0d", r.name, k), held_insn[k],
                               bundle_insn_o[k]);
                check_fault({r.name, " stall fault"}, held_fault, bundle_fault_o);
            end
            held = 1'b0;
            if (bundle_valid_o && bundle_ready_i) begin
                check_addr({r.name, " pc"}, pc, bundle_pc_o);
                for (int k = 0; k < num_lanes; k++)
                    check_word($sformatf("%s slot %0d", r.name, k), exp_word(pc + addr_t'(4 * k)),
                               bundle_insn_o[k]);
                check_fault({r.name, " fault"}, exp_faults(pc), bundle_fault_o);
                pc = pc + addr_t'(bundle_stride); // Next bundle in program order
                taken = taken + 1;
                idle = 0;
            end else begin
                if (bundle_valid_o) begin
                    held = 1'b1;
                    held_pc = bundle_pc_o;
                    held_insn = bundle_insn_o;
                    held_fault = bundle_fault_o;
                end
                idle = idle + 1;
                if (idle > wait_limit) abort_run($sformatf("%s: timeout waiting for a bundle", r.name));
            end
            next_drive();
        end
        bundle_ready_i = 1'b0;
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        rst_n = 1'b1; // Active high, DUT held in reset
        load_valid_i = 1'b0;
        load_idx_i = '0;
        load_data_i = '0;
        redirect_valid_i = 1'b0;
        redirect_pc_i = '0;
        bundle_ready_i = 1'b0;
        cyc = '0;
        lcg_state = 32'he77f_1c13;

        add_row(1'b0, '0, 3, 8'hFF, 1'b0, "reset_first");
        add_row(1'b0, '0, 6, 8'hFF, 1'b0, "stream");
        add_row(1'b0, '0, 5, 8'b1100_0001, 1'b0, "backpressure"); // Low for 5 cycles
        add_row(1'b1, inst_base_addr + 32'h100, 4, 8'hFF, 1'b0, "redirect");
        add_row(1'b1, inst_base_addr + addr_t'(4 * (mem_depth - 1)), 2, 8'hFF, 1'b0, "fault_top");
        add_row(1'b1, 32'h7FFF_FFF0, 3, 8'b1011_0111, 1'b0, "fault_low"); // Below base
        add_row(1'b1, inst_base_addr + 32'h40, 3, 8'hFF, 1'b1, "reload");
        add_row(1'b1, inst_base_addr + 32'h3E8, 4, 8'b0111_0011, 1'b0, "cross_top");

        next_drive();
        load_program();          // Program goes in under reset
        repeat (8) next_drive(); // Then 8 more reset cycles
        rst_n = 1'b0;
        exp_pc = inst_base_addr;

        foreach (stim[i]) begin
            if (stim[i].redir) begin
                if (stim[i].reload) rewrite_word(stim[i].pc);
                redirect_to(stim[i].pc, stim[i].name);
                exp_pc = stim[i].pc;
            end
            take_bundles(stim[i], exp_pc);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

// File: verilog.f
logic/mem_map_pkg.sv
logic/fetch_pkg.sv
logic/inst_mem.sv
logic/fetch_sequencer.sv
logic/fetch_lane.sv
logic/bundle_collector.sv
logic/fetch_top.sv
verif/fetch_tb.sv

// File: Makefile
# Verilator build and run for the fetch subsystem testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Everything OK" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
